//--- source/msx_defines.svh
`ifndef MSX_DEFINES_SVH
`define MSX_DEFINES_SVH

// CPU address and page geometry
`define MSX_ADDR_W 16
`define MSX_PAGE_W 14

// Internal block RAM, counted in 16 KB banks
`define MSX_BANKS 8
`define MSX_BANK_W 3

// Slot select port and subslot register location
`define MSX_SLOT_PORT 8'hA8
`define MSX_SUBSLOT_ADDR 16'hFFFF

// One bit per primary slot, set where an expander is fitted
`define MSX_EXPANDED 4'b1000

`endif

//--- source/msx_bus_pkg.sv
`default_nettype none

`include "msx_defines.svh"

package msx_bus_pkg;

   // One host request as it enters the core
   typedef struct packed {
      logic [`MSX_ADDR_W-1:0] addr;
      logic [7:0]             wdata;
      logic                   wr;
      logic                   io;
   } bus_req_t;

   // Writes answer too, so the host sees every access in order
   typedef struct packed {
      logic [7:0] data;
      logic       wr;
   } bus_rsp_t;

   // Encoded as {io, wr}
   typedef enum logic [1:0] {
      ACC_MEM_RD = 2'b00,
      ACC_MEM_WR = 2'b01,
      ACC_IO_RD  = 2'b10,
      ACC_IO_WR  = 2'b11
   } access_kind_t;

endpackage

`default_nettype wire

//--- source/msx_slot_pkg.sv
`default_nettype none

`include "msx_defines.svh"

package msx_slot_pkg;

   // What backs a 16 KB block
   typedef enum logic [1:0] {
      BLK_EMPTY = 2'd0,
      BLK_RAM   = 2'd1,
      BLK_ROM   = 2'd2
   } block_kind_t;

   // One entry of the slot layout table
   typedef struct packed {
      block_kind_t            kind;
      logic [`MSX_BANK_W-1:0] bank;
   } block_t;

   // Table index, slot in the top bits and page in the bottom
   typedef struct packed {
      logic [1:0] slot;
      logic [1:0] subslot;
      logic [1:0] page;
   } layout_id_t;

endpackage

`default_nettype wire

//--- source/msx_cpu_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "msx_defines.svh"

interface msx_cpu_bus_if;

   // Access issued by the sequencer, held until the next accept
   logic                   strobe;
   logic [`MSX_ADDR_W-1:0] addr;
   logic [7:0]             wdata;
   logic                   wr;
   logic                   io;

   // Slot routing for the page of addr
   logic [1:0]             slot;
   logic [1:0]             subslot;

   modport seq (output strobe, output addr, output wdata, output wr, output io);

   modport regs (input strobe, input addr, input wdata, input wr, input io,
                 output slot, output subslot);

   modport map (input strobe, input addr, input wdata, input wr, input io,
                input slot, input subslot);

endinterface

`default_nettype wire

//--- source/msx_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module msx_pipe_reg #(
   parameter type payload_t = logic [7:0]
) (
   input  wire logic clock_bus,
   input  wire logic rst_n,
   input  wire logic in_valid,
   output logic      in_ready,
   input  payload_t  in_data,
   output logic      out_valid,
   input  wire logic out_ready,
   output payload_t  out_data
);

   logic     skid_valid;
   payload_t skid_data;

   // Room as long as the skid entry is free
   assign in_ready = !skid_valid;

   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
      end else if (out_ready || !out_valid) begin
         if (skid_valid) begin
            out_valid  <= 1'b1;
            skid_valid <= 1'b0;
         end else begin
            out_valid <= in_valid;
         end
      end else if (in_valid && in_ready) begin
         // Output stalled, park the new word
         skid_valid <= 1'b1;
      end
   end

   always_ff @(posedge clock_bus) begin
      if (out_ready || !out_valid) begin
         out_data <= skid_valid ? skid_data : in_data;
      end else if (in_valid && in_ready) begin
         skid_data <= in_data;
      end
   end

   a_hold_stable: assert property (@(posedge clock_bus) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
      else $error("msx_pipe_reg output changed while stalled");

endmodule

`default_nettype wire

//--- source/msx_bus_seq.sv
`timescale 1ns/1ps
`default_nettype none

module msx_bus_seq
   import msx_bus_pkg::*;
(
   input  wire logic   clock_bus,
   input  wire logic   rst_n,
   input  wire logic   req_valid,
   output logic        req_ready,
   input  bus_req_t    req,
   output logic        rsp_valid,
   input  wire logic   rsp_ready,
   output bus_rsp_t    rsp,
   msx_cpu_bus_if.seq  cpu,
   input  wire logic   regs_hit,
   input  wire logic [7:0] regs_rdata,
   input  wire logic [7:0] mem_rdata,
   output logic        mem_busy
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ISSUE,
      ST_COLLECT
   } state_t;

   state_t       state;
   bus_req_t     cur;
   access_kind_t acc_kind;

   // Only take a request when the output slice can hold its answer
   assign req_ready = (state == ST_IDLE) && rsp_ready;

   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE:    if (req_valid && req_ready) state <= ST_ISSUE;
            ST_ISSUE:   state <= ST_COLLECT;
            ST_COLLECT: if (rsp_ready) state <= ST_IDLE;
            default:    state <= ST_IDLE;
         endcase
      end
   end

   // Access payload, held on the bus until the next accept
   always_ff @(posedge clock_bus) begin
      if (req_valid && req_ready) begin
         cur <= req;
      end
   end

   assign cpu.strobe = (state == ST_ISSUE);
   assign cpu.addr   = cur.addr;
   assign cpu.wdata  = cur.wdata;
   assign cpu.wr     = cur.wr;
   assign cpu.io     = cur.io;

   // Layout table must not change under a lookup
   assign mem_busy = (state == ST_ISSUE);

   assign acc_kind = access_kind_t'({cur.io, cur.wr});

   // Read data priority: slot registers, then memory, then open bus
   always_comb begin
      case (acc_kind)
         ACC_MEM_RD: rsp.data = regs_hit ? regs_rdata : mem_rdata;
         ACC_IO_RD:  rsp.data = regs_hit ? regs_rdata : 8'hFF;
         default:    rsp.data = cur.wdata;
      endcase
   end

   assign rsp.wr    = cur.wr;
   assign rsp_valid = (state == ST_COLLECT);

   // Slice room checked at accept must still be there at collect
   a_rsp_room: assert property (@(posedge clock_bus) disable iff (!rst_n)
      cpu.strobe |=> rsp_valid && rsp_ready)
      else $error("msx_bus_seq strobe issued while a response is pending");

endmodule

`default_nettype wire

//--- source/msx_slot_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "msx_defines.svh"

module msx_slot_regs (
   input  wire logic   clock_bus,
   input  wire logic   rst_n,
   msx_cpu_bus_if.regs cpu,
   output logic        hit,
   output logic [7:0]  rdata
);

   localparam logic [3:0] EXPANDED_MAP = `MSX_EXPANDED;

   logic [7:0] prim_slot;
   logic       prim_written;
   logic [7:0] sub_reg [4];
   logic [1:0] page;
   logic [1:0] act_slot;
   logic [1:0] act_subslot;
   logic       expanded;
   logic       port_sel;
   logic       sub_sel;

   assign page = cpu.addr[15:14];

   // Everything sits in slot 0 until the port is first written
   assign act_slot = prim_written ? prim_slot[2*page +: 2] : 2'd0;
   assign expanded = EXPANDED_MAP[act_slot];
   assign act_subslot = expanded ? sub_reg[act_slot][2*page +: 2] : 2'd0;

   assign cpu.slot    = act_slot;
   assign cpu.subslot = act_subslot;

   // I/O space decodes the low address byte only
   assign port_sel = cpu.io && (cpu.addr[7:0] == `MSX_SLOT_PORT);
   assign sub_sel  = !cpu.io && (cpu.addr == `MSX_SUBSLOT_ADDR) && expanded;

   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         prim_slot    <= 8'h00;
         prim_written <= 1'b0;
         sub_reg      <= '{default: 8'h00};
         hit          <= 1'b0;
      end else if (cpu.strobe) begin
         hit <= port_sel || sub_sel;
         if (cpu.wr && port_sel) begin
            prim_slot    <= cpu.wdata;
            prim_written <= 1'b1;
         end
         // A RAM block behind FFFFh is written as well
         if (cpu.wr && sub_sel) begin
            sub_reg[act_slot] <= cpu.wdata;
         end
      end
   end

   // Registered so it lines up with the RAM read
   always_ff @(posedge clock_bus) begin
      if (cpu.strobe) begin
         rdata <= port_sel ? prim_slot : ~sub_reg[act_slot];
      end
   end

endmodule

`default_nettype wire

//--- source/msx_slot_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "msx_defines.svh"

module msx_slot_map
   import msx_slot_pkg::*;
(
   input  wire logic  clock_bus,
   input  wire logic  rst_n,
   msx_cpu_bus_if.map cpu,
   input  wire logic  mem_busy,
   input  wire logic  cfg_valid,
   output logic       cfg_ready,
   input  layout_id_t cfg_index,
   input  block_t     cfg_block,
   output logic [7:0] rdata
);

   localparam int RAM_AW    = `MSX_BANK_W + `MSX_PAGE_W;
   localparam int RAM_DEPTH = `MSX_BANKS * (2 ** `MSX_PAGE_W);

   block_t      layout [64];
   layout_id_t  look_id;
   block_t      blk;
   logic [RAM_AW-1:0] ram_addr;
   logic [7:0]  ram [RAM_DEPTH];
   logic [7:0]  ram_q;
   logic        rd_empty;
   logic        mem_acc;

   assign cfg_ready = !mem_busy;

   // Slot 0 starts as plain RAM, banks 0 to 3 in page order
   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         for (int i = 0; i < 64; i++) begin
            if (i < 16) begin
               layout[i] <= '{kind: BLK_RAM, bank: `MSX_BANK_W'(i % 4)};
            end else begin
               layout[i] <= '{kind: BLK_EMPTY, bank: '0};
            end
         end
      end else if (cfg_valid && cfg_ready) begin
         layout[cfg_index] <= cfg_block;
      end
   end

   assign look_id  = '{slot: cpu.slot, subslot: cpu.subslot, page: cpu.addr[15:14]};
   assign blk      = layout[look_id];
   assign ram_addr = {blk.bank, cpu.addr[`MSX_PAGE_W-1:0]};
   assign mem_acc  = cpu.strobe && !cpu.io;

   // ROM blocks share the RAM but ignore writes
   always_ff @(posedge clock_bus) begin
      if (mem_acc && cpu.wr && blk.kind == BLK_RAM) begin
         ram[ram_addr] <= cpu.wdata;
      end
      if (mem_acc && !cpu.wr) begin
         ram_q    <= ram[ram_addr];
         rd_empty <= (blk.kind == BLK_EMPTY);
      end
   end

   // Empty blocks float high
   assign rdata = rd_empty ? 8'hFF : ram_q;

   a_bank_range: assert property (@(posedge clock_bus) disable iff (!rst_n)
      mem_acc && blk.kind != BLK_EMPTY |-> int'(blk.bank) < `MSX_BANKS)
      else $error("msx_slot_map bank index out of range");

endmodule

`default_nettype wire

//--- source/msx_bus_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "msx_defines.svh"

module msx_bus_core
   import msx_bus_pkg::*;
   import msx_slot_pkg::*;
(
   input  wire logic                   clock_bus,
   input  wire logic                   rst_n,
   input  wire logic                   req_valid,
   output logic                        req_ready,
   input  wire logic [`MSX_ADDR_W-1:0] req_addr,
   input  wire logic [7:0]             req_wdata,
   input  wire logic                   req_wr,
   input  wire logic                   req_io,
   output logic                        rsp_valid,
   input  wire logic                   rsp_ready,
   output logic [7:0]                  rsp_data,
   output logic                        rsp_wr,
   input  wire logic                   cfg_valid,
   output logic                        cfg_ready,
   input  layout_id_t                  cfg_index,
   input  block_t                      cfg_block
);

   msx_cpu_bus_if cpu ();

   bus_req_t   req_in;
   bus_req_t   req_q;
   logic       req_q_valid;
   logic       req_q_ready;
   bus_rsp_t   rsp_d;
   bus_rsp_t   rsp_out;
   logic       rsp_d_valid;
   logic       rsp_d_ready;
   logic       regs_hit;
   logic [7:0] regs_rdata;
   logic [7:0] mem_rdata;
   logic       mem_busy;

   assign req_in   = '{addr: req_addr, wdata: req_wdata, wr: req_wr, io: req_io};
   assign rsp_data = rsp_out.data;
   assign rsp_wr   = rsp_out.wr;

   msx_pipe_reg #(.payload_t(bus_req_t)) u_req_slice (
      .clock_bus(clock_bus), .rst_n(rst_n),
      .in_valid(req_valid), .in_ready(req_ready), .in_data(req_in),
      .out_valid(req_q_valid), .out_ready(req_q_ready), .out_data(req_q)
   );

   msx_bus_seq u_seq (
      .clock_bus(clock_bus), .rst_n(rst_n),
      .req_valid(req_q_valid), .req_ready(req_q_ready), .req(req_q),
      .rsp_valid(rsp_d_valid), .rsp_ready(rsp_d_ready), .rsp(rsp_d),
      .cpu(cpu.seq),
      .regs_hit(regs_hit), .regs_rdata(regs_rdata),
      .mem_rdata(mem_rdata), .mem_busy(mem_busy)
   );

   msx_slot_regs u_slot_regs (
      .clock_bus(clock_bus), .rst_n(rst_n),
      .cpu(cpu.regs), .hit(regs_hit), .rdata(regs_rdata)
   );

   msx_slot_map u_slot_map (
      .clock_bus(clock_bus), .rst_n(rst_n),
      .cpu(cpu.map), .mem_busy(mem_busy),
      .cfg_valid(cfg_valid), .cfg_ready(cfg_ready),
      .cfg_index(cfg_index), .cfg_block(cfg_block),
      .rdata(mem_rdata)
   );

   msx_pipe_reg #(.payload_t(bus_rsp_t)) u_rsp_slice (
      .clock_bus(clock_bus), .rst_n(rst_n),
      .in_valid(rsp_d_valid), .in_ready(rsp_d_ready), .in_data(rsp_d),
      .out_valid(rsp_valid), .out_ready(rsp_ready), .out_data(rsp_out)
   );

endmodule

`default_nettype wire

//--- bench/msx_bus_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "msx_defines.svh"

module msx_bus_checker
   import msx_slot_pkg::*;
(
   input  wire logic        clock_bus,
   input  wire logic        rst_n,
   input  wire logic        req_valid,
   input  wire logic        req_ready,
   input  wire logic [15:0] req_addr,
   input  wire logic [7:0]  req_wdata,
   input  wire logic        req_wr,
   input  wire logic        req_io,
   input  wire logic        rsp_valid,
   input  wire logic        rsp_ready,
   input  wire logic [7:0]  rsp_data,
   input  wire logic        rsp_wr,
   input  wire logic        cfg_valid,
   input  wire logic        cfg_ready,
   input  wire layout_id_t  cfg_index,
   input  wire block_t      cfg_block,
   input  wire logic        timing_check,
   output int               err_count,
   output int               req_count,
   output int               rsp_count
);

   localparam logic [3:0] EXPANDED_MAP = `MSX_EXPANDED;

   // Reference state of the bus core
   logic [7:0] prim_m;
   logic       prim_written_m;
   logic [7:0] sub_m [4];
   block_t     layout_m [64];
   logic [7:0] ram_m [int];

   // Expected responses in issue order
   logic [7:0] exp_data_q [$];
   logic       exp_known_q [$];
   logic       exp_wr_q [$];

   int   cycle;
   int   timed_start;
   logic timed_pending;
   logic was_reset;

   task automatic flag_error(input string msg);
      $display("[FAIL] %0t: %s", $time, msg);
      err_count++;
   endtask

   function automatic void reset_model();
      prim_m = 8'h00;
      prim_written_m = 1'b0;
      for (int i = 0; i < 4; i++) begin
         sub_m[i] = 8'h00;
      end
      // Slot 0 pages start on banks 0 to 3 in every subslot
      for (int i = 0; i < 64; i++) begin
         layout_m[i].kind = (i < 16) ? BLK_RAM : BLK_EMPTY;
         layout_m[i].bank = (i < 16) ? 3'(i % 4) : 3'd0;
      end
      ram_m.delete();
   endfunction

   // Applies one access to the reference state and returns the read data
   function automatic logic [7:0] model_access(input logic [15:0] addr,
         input logic [7:0] wdata, input logic wr, input logic io, output logic known);
      logic [1:0] page;
      logic [1:0] slot;
      logic [1:0] sub;
      logic       expd;
      block_t     blk;
      int         idx;
      logic [7:0] data;
      page  = addr[15:14];
      slot  = prim_written_m ? prim_m[2*page +: 2] : 2'd0;
      expd  = EXPANDED_MAP[slot];
      sub   = expd ? sub_m[slot][2*page +: 2] : 2'd0;
      blk   = layout_m[{slot, sub, page}];
      idx   = int'(blk.bank) * (2 ** `MSX_PAGE_W) + int'(addr[`MSX_PAGE_W-1:0]);
      known = !wr;
      data  = 8'hFF;
      if (io) begin
         if (addr[7:0] == `MSX_SLOT_PORT) begin
            if (wr) begin
               prim_m = wdata;
               prim_written_m = 1'b1;
            end else begin
               data = prim_m;
            end
         end
      end else if (addr == `MSX_SUBSLOT_ADDR && expd) begin
         // The block under FFFFh sees the write too, with the old subslot
         if (wr) begin
            sub_m[slot] = wdata;
            if (blk.kind == BLK_RAM) begin
               ram_m[idx] = wdata;
            end
         end else begin
            data = ~sub_m[slot];
         end
      end else if (wr) begin
         if (blk.kind == BLK_RAM) begin
            ram_m[idx] = wdata;
         end
      end else if (blk.kind != BLK_EMPTY) begin
         if (ram_m.exists(idx)) begin
            data = ram_m[idx];
         end else begin
            known = 1'b0;
         end
      end
      return data;
   endfunction

   // Sampled mid-cycle where all ports are settled
   always @(negedge clock_bus) begin
      logic [7:0] exp_data;
      logic       exp_known;
      logic       exp_wr;
      logic       exp_cfg_ready;
      if (!rst_n) begin
         reset_model();
         exp_data_q.delete();
         exp_known_q.delete();
         exp_wr_q.delete();
         err_count = 0;
         req_count = 0;
         rsp_count = 0;
         cycle = 0;
         timed_pending = 1'b0;
         was_reset = 1'b1;
      end else begin
         cycle++;
         if (was_reset) begin
            was_reset = 1'b0;
            if (!req_ready || !cfg_ready || rsp_valid) begin
               flag_error("ports not idle after reset");
            end
         end
         if (timed_pending && rsp_valid) begin
            timed_pending = 1'b0;
            if (cycle - timed_start != 4) begin
               flag_error($sformatf("response latency %0d, expected 4", cycle - timed_start));
            end
         end
         // Issue strobe of the timed read falls in the second cycle
         if (timed_pending && cycle - timed_start <= 3) begin
            exp_cfg_ready = (cycle - timed_start != 2);
            if (cfg_ready !== exp_cfg_ready) begin
               flag_error($sformatf("cfg_ready %b in cycle %0d after request, expected %b",
                  cfg_ready, cycle - timed_start, exp_cfg_ready));
            end
         end
         if (rsp_valid && rsp_ready) begin
            rsp_count++;
            if (exp_data_q.size() == 0) begin
               flag_error("response without a pending request");
            end else begin
               exp_data  = exp_data_q.pop_front();
               exp_known = exp_known_q.pop_front();
               exp_wr    = exp_wr_q.pop_front();
               if (rsp_wr !== exp_wr) begin
                  flag_error($sformatf("response %0d wr flag %b, expected %b",
                     rsp_count, rsp_wr, exp_wr));
               end else if (exp_known && rsp_data !== exp_data) begin
                  flag_error($sformatf("response %0d data %h, expected %h",
                     rsp_count, rsp_data, exp_data));
               end
            end
         end
         if (cfg_valid && cfg_ready) begin
            layout_m[cfg_index] = cfg_block;
         end
         if (req_valid && req_ready) begin
            req_count++;
            exp_data = model_access(req_addr, req_wdata, req_wr, req_io, exp_known);
            exp_data_q.push_back(exp_data);
            exp_known_q.push_back(exp_known);
            exp_wr_q.push_back(req_wr);
            if (timing_check) begin
               timed_pending = 1'b1;
               timed_start = cycle;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- bench/tb_msx_bus_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "msx_defines.svh"

module tb_msx_bus_core
   import msx_slot_pkg::*;
();

   logic        clock_bus;
   logic        rst_n;
   logic        req_valid;
   logic        req_ready;
   logic [15:0] req_addr;
   logic [7:0]  req_wdata;
   logic        req_wr;
   logic        req_io;
   logic        rsp_valid;
   logic        rsp_ready;
   logic [7:0]  rsp_data;
   logic        rsp_wr;
   logic        cfg_valid;
   logic        cfg_ready;
   layout_id_t  cfg_index;
   block_t      cfg_block;
   logic        timing_check;
   logic        bp_enable;
   logic [31:0] seed;
   logic [31:0] bp_rnd;
   int          err_count;
   int          req_count;
   int          rsp_count;
   int          timeouts;

   msx_bus_core u_msx_bus_core (
      .clock_bus(clock_bus), .rst_n(rst_n),
      .req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
      .req_wdata(req_wdata), .req_wr(req_wr), .req_io(req_io),
      .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data), .rsp_wr(rsp_wr),
      .cfg_valid(cfg_valid), .cfg_ready(cfg_ready),
      .cfg_index(cfg_index), .cfg_block(cfg_block)
   );

   msx_bus_checker u_checker (
      .clock_bus(clock_bus), .rst_n(rst_n),
      .req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
      .req_wdata(req_wdata), .req_wr(req_wr), .req_io(req_io),
      .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data), .rsp_wr(rsp_wr),
      .cfg_valid(cfg_valid), .cfg_ready(cfg_ready),
      .cfg_index(cfg_index), .cfg_block(cfg_block),
      .timing_check(timing_check),
      .err_count(err_count), .req_count(req_count), .rsp_count(rsp_count)
   );

   always #50 clock_bus = ~clock_bus;

   // Response back-pressure, three cycles in four ready when enabled
   always @(posedge clock_bus) begin
      #1;
      bp_rnd = $urandom;
      rsp_ready = !bp_enable || (bp_rnd[1:0] != 2'b00);
   end

   task automatic send_req(input logic [15:0] addr, input logic [7:0] wdata,
         input logic wr, input logic io);
      int   n;
      logic done;
      if (timeouts != 0) return;
      req_addr  = addr;
      req_wdata = wdata;
      req_wr    = wr;
      req_io    = io;
      req_valid = 1'b1;
      done = 1'b0;
      n = 0;
      while (!done && n < 200) begin
         @(negedge clock_bus);
         done = req_ready;
         @(posedge clock_bus);
         #1;
         n++;
      end
      req_valid = 1'b0;
      if (!done) begin
         $display("Timeout: request to %h was not accepted within %0d cycles", addr, n);
         timeouts++;
      end
   endtask

   task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
      send_req(addr, data, 1'b1, 1'b0);
   endtask

   task automatic mem_read(input logic [15:0] addr);
      send_req(addr, 8'h00, 1'b0, 1'b0);
   endtask

   task automatic io_write(input logic [7:0] port, input logic [7:0] data);
      send_req({8'h00, port}, data, 1'b1, 1'b1);
   endtask

   task automatic io_read(input logic [7:0] port);
      send_req({8'h00, port}, 8'h00, 1'b0, 1'b1);
   endtask

   // Waits until every accepted request has been answered
   task automatic wait_idle();
      int n;
      if (timeouts != 0) return;
      n = 0;
      while (req_count != rsp_count && n < 2000) begin
         @(posedge clock_bus);
         #1;
         n++;
      end
      if (req_count != rsp_count) begin
         $display("Timeout: %0d responses still missing", req_count - rsp_count);
         timeouts++;
      end
   endtask

   // Layout writes only go out on an idle bus
   task automatic send_cfg(input logic [1:0] slot, input logic [1:0] sub,
         input logic [1:0] page, input block_kind_t kind, input logic [2:0] bank);
      int   n;
      logic done;
      wait_idle();
      if (timeouts != 0) return;
      cfg_index = {slot, sub, page};
      cfg_block.kind = kind;
      cfg_block.bank = bank;
      cfg_valid = 1'b1;
      done = 1'b0;
      n = 0;
      while (!done && n < 200) begin
         @(negedge clock_bus);
         done = cfg_ready;
         @(posedge clock_bus);
         #1;
         n++;
      end
      cfg_valid = 1'b0;
      if (!done) begin
         $display("Timeout: layout write was not accepted within %0d cycles", n);
         timeouts++;
      end
   endtask

   task automatic random_cfg();
      logic [31:0] r;
      block_kind_t kind;
      r = $urandom;
      case (r[7:6])
         2'd0:    kind = BLK_EMPTY;
         2'd2:    kind = BLK_ROM;
         default: kind = BLK_RAM;
      endcase
      send_cfg(r[5:4], r[3:2], r[1:0], kind, r[10:8]);
   endtask

   // Few offsets per page so reads often land on written bytes
   task automatic random_req();
      logic [31:0] r;
      logic [15:0] addr;
      r = $urandom;
      addr = {r[1:0], 10'h000, r[5:2]};
      case (r[11:8])
         4'd0:    io_write(`MSX_SLOT_PORT, r[23:16]);
         4'd1:    io_read(r[23:16]);
         4'd2:    mem_write(`MSX_SUBSLOT_ADDR, r[23:16]);
         4'd3:    mem_read(`MSX_SUBSLOT_ADDR);
         4'd4, 4'd5, 4'd6, 4'd7, 4'd8: mem_write(addr, r[23:16]);
         default: mem_read(addr);
      endcase
   endtask

   initial begin
      clock_bus = 1'b0;
      rst_n = 1'b0;
      req_valid = 1'b0;
      req_addr = '0;
      req_wdata = '0;
      req_wr = 1'b0;
      req_io = 1'b0;
      rsp_ready = 1'b1;
      cfg_valid = 1'b0;
      cfg_index = '0;
      cfg_block = '0;
      timing_check = 1'b0;
      bp_enable = 1'b0;
      timeouts = 0;
      seed = $urandom(51);
      repeat (8) @(posedge clock_bus);
      #1;
      rst_n = 1'b1;

      // Default map, slot 0 in every page
      for (int p = 0; p < 4; p++) begin
         mem_write({p[1:0], 14'h0123}, {6'd4, p[1:0]});
      end
      for (int p = 0; p < 4; p++) begin
         mem_read({p[1:0], 14'h0123});
      end

      // Primary slot remap and open I/O reads
      io_write(`MSX_SLOT_PORT, 8'h64);
      io_read(`MSX_SLOT_PORT);
      for (int p = 0; p < 4; p++) begin
         mem_read({p[1:0], 14'h0123});
      end
      io_write(8'h98, 8'h3C);
      io_read(8'h99);
      io_write(`MSX_SLOT_PORT, 8'h00);

      // Subslots of the expanded slot 3 in page 3
      send_cfg(2'd3, 2'd0, 2'd3, BLK_RAM, 3'd4);
      send_cfg(2'd3, 2'd2, 2'd3, BLK_RAM, 3'd5);
      io_write(`MSX_SLOT_PORT, 8'hC0);
      mem_write(`MSX_SUBSLOT_ADDR, 8'h00);
      mem_write(16'hC010, 8'hAA);
      mem_write(`MSX_SUBSLOT_ADDR, 8'h80);
      mem_write(16'hC010, 8'h55);
      mem_read(16'hC010);
      mem_read(`MSX_SUBSLOT_ADDR);
      mem_write(`MSX_SUBSLOT_ADDR, 8'h00);
      mem_read(16'hC010);
      io_write(`MSX_SLOT_PORT, 8'h00);
      mem_write(`MSX_SUBSLOT_ADDR, 8'h5A);
      mem_read(`MSX_SUBSLOT_ADDR);

      // Layout rewrites with other banks, empty and ROM blocks
      send_cfg(2'd0, 2'd0, 2'd1, BLK_RAM, 3'd6);
      mem_write(16'h4010, 8'h11);
      mem_read(16'h4010);
      send_cfg(2'd0, 2'd0, 2'd1, BLK_RAM, 3'd1);
      mem_read(16'h4123);
      send_cfg(2'd0, 2'd0, 2'd2, BLK_EMPTY, 3'd0);
      mem_read(16'h8123);
      mem_write(16'h8123, 8'h77);
      send_cfg(2'd0, 2'd0, 2'd2, BLK_RAM, 3'd2);
      mem_read(16'h8123);
      send_cfg(2'd0, 2'd0, 2'd1, BLK_ROM, 3'd6);
      mem_write(16'h4010, 8'h99);
      mem_read(16'h4010);
      send_cfg(2'd0, 2'd0, 2'd1, BLK_RAM, 3'd1);

      // Single read latency on an idle core
      wait_idle();
      timing_check = 1'b1;
      mem_read(16'h0123);
      timing_check = 1'b0;
      wait_idle();

      // Random stream under back-pressure
      bp_enable = 1'b1;
      repeat (6) begin
         random_cfg();
         repeat (40) begin
            random_req();
         end
      end
      wait_idle();
      bp_enable = 1'b0;

      $display("Error counts: %0d mismatches, %0d timeouts, %0d requests, %0d responses",
         err_count, timeouts, req_count, rsp_count);
      if (err_count == 0 && timeouts == 0 && req_count == rsp_count) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- msx_bus_core.f
+incdir+source
source/msx_bus_pkg.sv
source/msx_slot_pkg.sv
source/msx_cpu_bus_if.sv
source/msx_pipe_reg.sv
source/msx_bus_seq.sv
source/msx_slot_regs.sv
source/msx_slot_map.sv
source/msx_bus_core.sv
bench/msx_bus_checker.sv
bench/tb_msx_bus_core.sv

//--- Makefile
TOOL       = verilator
TOP        = tb_msx_bus_core
FILELIST   = msx_bus_core.f
FLAGS      = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/1ps
OBJ_DIR    = obj_dir
PASS_MSG   = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
